/* verilog.f */
+incdir+source
source/jtag_tap_pkg.sv
source/dmi_pkg.sv
source/jtag_tap_ctrl.sv
source/dmi_scan.sv
source/sb_access.sv
source/scratch_mem.sv
source/jtag_dbg_top.sv
bench/jtag_dbg_assertions.sv
bench/jtag_dbg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module jtag_dbg_tb \
  -o jtag_dbg_sim || { echo "build error"; exit 1; }
sim_out=$(./obj_dir/jtag_dbg_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "all tests passed" && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

/* bench/jtag_dbg_tb.sv */
/*
 * Testbench for the JTAG debug target
 * Clock and reset, JTAG bit driver, IR and DR scans,
 * DMI read and write, compare tasks, directed tests, timeout
 */

`timescale 1ns/10ps

`include "jtag_dbg_consts.svh"

module jtag_dbg_tb;

  // About 3000 cycles of scans with twice that as headroom
  localparam int TimeoutCycles = 6000;

  logic   jtag_tck, rst, jtag_tms, jtag_tdi, jtag_tdo;
  integer seed = 90292;
  int     cycle_cnt, test_errs, tests_ok, tests_bad;
  string  test_name;

  jtag_dbg_top jtag_dbg_top_i (
    .jtag_tck   (jtag_tck),
    .rst_i      (rst),
    .jtag_tms_i (jtag_tms),
    .jtag_tdi_i (jtag_tdi),
    .jtag_tdo_o (jtag_tdo)
  );

  initial begin
    jtag_tck = 1'b0;
    forever #5 jtag_tck = ~jtag_tck;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge jtag_tck);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////
  // JTAG driver
  ////////////////////////////////////////

  // TDO is sampled before the new TMS and TDI go out
  task automatic clock_bit(input logic tms, input logic tdi, output logic tdo);
    @(negedge jtag_tck);
    tdo = jtag_tdo;
    jtag_tms = tms;
    jtag_tdi = tdi;
  endtask

  task automatic run_idle(input int cycles);
    logic tdo;
    repeat (cycles) clock_bit(1'b0, 1'b0, tdo);
  endtask

  task automatic jtag_reset_tap();
    logic tdo;
    repeat (5) clock_bit(1'b1, 1'b0, tdo);
    clock_bit(1'b0, 1'b0, tdo);
  endtask

  // Starts and ends in Run-Test/Idle and shifts LSB first
  task automatic scan_chain(input logic is_ir, input int len, input logic [63:0] din,
                            output logic [63:0] dout);
    logic tdo;
    int   i;
    dout = '0;
    clock_bit(1'b1, 1'b0, tdo);
    if (is_ir) clock_bit(1'b1, 1'b0, tdo);
    clock_bit(1'b0, 1'b0, tdo);
    clock_bit(1'b0, 1'b0, tdo);
    for (i = 0; i < len; i++) begin
      clock_bit(i == len - 1, din[i], tdo);
      dout[i] = tdo;
    end
    clock_bit(1'b1, 1'b0, tdo);
    clock_bit(1'b0, 1'b0, tdo);
  endtask

  task automatic shift_ir(input logic [4:0] ir);
    logic [63:0] dout;
    scan_chain(1'b1, 5, 64'(ir), dout);
  endtask

  task automatic shift_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
    scan_chain(1'b0, len, din, dout);
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
    logic [63:0] dout;
    shift_dr(41, 64'({addr, data, dmi_pkg::WRITE}), dout);
    run_idle(4);
  endtask

  // Response of the READ comes back with the following NOP scan
  task automatic dmi_read(input logic [6:0] addr, output dmi_pkg::dmi_rsp_t rsp);
    logic [63:0] dout;
    shift_dr(41, 64'({addr, 32'h0, dmi_pkg::READ}), dout);
    shift_dr(41, 64'({7'h0, 32'h0, dmi_pkg::NOP}), dout);
    rsp = dmi_pkg::dmi_rsp_t'(dout[33:0]);
  endtask

  ////////////////////////////////////////
  // Expected values and compares
  ////////////////////////////////////////

  function automatic dmi_pkg::sbcs_t sbcs_value(input logic onaddr, input logic autoinc,
                                                input logic ondata, input logic [2:0] err);
    dmi_pkg::sbcs_t v;
    v = '0;
    v.sbversion = 3'd1;
    v.sbaccess = 3'd2;
    v.sbreadonaddr = onaddr;
    v.sbautoincrement = autoinc;
    v.sbreadondata = ondata;
    v.sberror = err;
    return v;
  endfunction

  function automatic dmi_pkg::dmi_rsp_t ok_rsp(input logic [31:0] data);
    dmi_pkg::dmi_rsp_t r;
    r.data = data;
    r.status = `DMI_STATUS_OK;
    return r;
  endfunction

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_rsp(input string what, input dmi_pkg::dmi_rsp_t exp,
                           input dmi_pkg::dmi_rsp_t act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected data %h status %0d, actual data %h status %0d",
               test_name, what, exp.data, exp.status, act.data, act.status);
      test_errs++;
    end
  endtask

  task automatic check_sbcs(input string what, input dmi_pkg::sbcs_t exp,
                            input dmi_pkg::sbcs_t act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected sbcs %h, actual sbcs %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
      tests_ok++;
    end else begin
      $display("test %s: %0d mismatches", test_name, test_errs);
      tests_bad++;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_idcode();
    logic [63:0] dout;
    begin_test("idcode");
    shift_dr(32, 64'(0), dout);
    check_word("idcode", `JTAG_IDCODE, dout[31:0]);
    end_test();
  endtask

  // The single bypass stage captures 0 and delays by one bit
  task automatic test_bypass(input string name, input logic [4:0] ir);
    logic [31:0] din;
    logic [63:0] dout;
    begin_test(name);
    din = $random(seed);
    shift_ir(ir);
    shift_dr(32, 64'(din), dout);
    check_word("shifted pattern", {din[30:0], 1'b0}, dout[31:0]);
    end_test();
  endtask

  task automatic test_readback();
    dmi_pkg::dmi_rsp_t rsp;
    begin_test("readback");
    shift_ir(jtag_tap_pkg::DMI_ACCESS);
    dmi_read(dmi_pkg::SBCS, rsp);
    check_sbcs("sbcs reset", sbcs_value(1'b0, 1'b0, 1'b0, 3'd0), dmi_pkg::sbcs_t'(rsp.data));
    dmi_read(7'h10, rsp);
    check_rsp("unused address", ok_rsp(32'h0), rsp);
    end_test();
  endtask

  task automatic test_single();
    logic [31:0]       addr, data;
    dmi_pkg::dmi_rsp_t rsp;
    begin_test("single");
    addr = $random(seed) & 32'h3fc;
    data = $random(seed);
    dmi_write(dmi_pkg::SBCS, sbcs_value(1'b1, 1'b0, 1'b0, 3'd0));
    dmi_write(dmi_pkg::SBAddress0, addr);
    dmi_write(dmi_pkg::SBData0, data);
    dmi_write(dmi_pkg::SBAddress0, addr);
    dmi_read(dmi_pkg::SBData0, rsp);
    check_rsp("sbdata0", ok_rsp(data), rsp);
    end_test();
  endtask

  task automatic test_burst();
    logic [31:0]       words [8];
    dmi_pkg::dmi_rsp_t rsp;
    int                i;
    begin_test("burst");
    dmi_write(dmi_pkg::SBCS, sbcs_value(1'b0, 1'b1, 1'b1, 3'd0));
    dmi_write(dmi_pkg::SBAddress0, 32'h40);
    for (i = 0; i < 8; i++) begin
      words[i] = $random(seed);
      dmi_write(dmi_pkg::SBData0, words[i]);
    end
    dmi_write(dmi_pkg::SBCS, sbcs_value(1'b1, 1'b1, 1'b1, 3'd0));
    dmi_write(dmi_pkg::SBAddress0, 32'h40);
    for (i = 0; i < 8; i++) begin
      // No prefetch past the last word
      if (i == 7) dmi_write(dmi_pkg::SBCS, sbcs_value(1'b1, 1'b1, 1'b0, 3'd0));
      dmi_read(dmi_pkg::SBData0, rsp);
      check_rsp("burst word", ok_rsp(words[i]), rsp);
    end
    dmi_read(dmi_pkg::SBAddress0, rsp);
    check_word("final sbaddress0", 32'h40 + 32'd4 * 32'd8, rsp.data);
    end_test();
  endtask

  task automatic test_error();
    logic [31:0]       addr, d_old;
    dmi_pkg::dmi_rsp_t rsp;
    begin_test("bad address");
    addr = 32'h100;
    d_old = $random(seed);
    dmi_write(dmi_pkg::SBCS, sbcs_value(1'b1, 1'b0, 1'b0, 3'd0));
    dmi_write(dmi_pkg::SBAddress0, addr);
    dmi_write(dmi_pkg::SBData0, d_old);
    // Leave SBData0 different from the test word
    dmi_write(dmi_pkg::SBAddress0, addr + 32'd4);
    dmi_write(dmi_pkg::SBData0, ~d_old);
    dmi_write(dmi_pkg::SBAddress0, 32'h1000);
    dmi_read(dmi_pkg::SBCS, rsp);
    check_sbcs("sberror set", sbcs_value(1'b1, 1'b0, 1'b0, 3'd2), dmi_pkg::sbcs_t'(rsp.data));
    // Blocked while the error stands
    dmi_write(dmi_pkg::SBAddress0, addr);
    dmi_write(dmi_pkg::SBData0, ~d_old);
    dmi_write(dmi_pkg::SBCS, sbcs_value(1'b1, 1'b0, 1'b0, 3'd7));
    dmi_read(dmi_pkg::SBCS, rsp);
    check_sbcs("sberror clear", sbcs_value(1'b1, 1'b0, 1'b0, 3'd0), dmi_pkg::sbcs_t'(rsp.data));
    dmi_write(dmi_pkg::SBAddress0, addr);
    dmi_read(dmi_pkg::SBData0, rsp);
    check_rsp("word kept", ok_rsp(d_old), rsp);
    end_test();
  endtask

  initial begin
    rst = 1'b1;
    jtag_tms = 1'b1;
    jtag_tdi = 1'b0;
    tests_ok = 0;
    tests_bad = 0;
    repeat (10) @(negedge jtag_tck);
    rst = 1'b0;
    jtag_reset_tap();
    test_idcode();
    test_bypass("bypass", jtag_tap_pkg::BYPASS);
    test_bypass("unused ir", 5'h05);
    test_readback();
    test_single();
    test_burst();
    test_error();
    $display("%0d tests run, %0d ok, %0d with mismatches", tests_ok + tests_bad, tests_ok,
             tests_bad);
    if (tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* bench/jtag_dbg_assertions.sv */
/*
 * Bus access checks
 * Concurrent assertions bound into sb_access
 */

`timescale 1ns/10ps

module jtag_dbg_assertions (
  input logic           jtag_tck,
  input logic           rst_i,
  input logic           req_valid_i,
  input logic           mem_we_i,
  input logic           mem_re_i,
  input dmi_pkg::sbcs_t sbcs_i
);

  // One memory port, one access kind per cycle
  we_re_excl: assert property (@(posedge jtag_tck) disable iff (rst_i)
    !(mem_we_i && mem_re_i))
    else $error("mem_we and mem_re high in the same cycle");

  // A pending bus error blocks new accesses
  no_access_on_err: assert property (@(posedge jtag_tck) disable iff (rst_i)
    (mem_we_i || mem_re_i) |-> (sbcs_i.sberror == 3'd0))
    else $error("memory access started while sberror is set");

  // At most one request per DR scan
  req_single: assert property (@(posedge jtag_tck) disable iff (rst_i)
    req_valid_i |=> !req_valid_i)
    else $error("req_valid high on two consecutive cycles");

endmodule

bind sb_access jtag_dbg_assertions jtag_dbg_assertions_i (
  .jtag_tck    (jtag_tck),
  .rst_i       (rst_i),
  .req_valid_i (req_valid_i),
  .mem_we_i    (mem_we_o),
  .mem_re_i    (mem_re_o),
  .sbcs_i      (sbcs_q)
);

/* source/jtag_dbg_top.sv */
/*
 * JTAG debug target top level
 * TAP controller, scan chains, bus access unit
 * and scratch memory
 */

`timescale 1ns/10ps

`include "jtag_dbg_consts.svh"

module jtag_dbg_top (
  input  logic jtag_tck,
  input  logic rst_i,
  input  logic jtag_tms_i,
  input  logic jtag_tdi_i,
  output logic jtag_tdo_o
);

  jtag_tap_pkg::tap_ctrl_t tap_ctrl;
  logic                    ir_tdo, ir_shift;
  dmi_pkg::dmi_req_t       dmi_req;
  dmi_pkg::dmi_rsp_t       dmi_rsp;
  logic                    req_valid;
  logic                    mem_we, mem_re;
  logic [`MEM_AW-1:0]      mem_addr;
  logic [`DATA_W-1:0]      mem_wdata, mem_rdata;

  jtag_tap_ctrl jtag_tap_ctrl_i (
    .jtag_tck   (jtag_tck),
    .rst_i      (rst_i),
    .jtag_tms_i (jtag_tms_i),
    .jtag_tdi_i (jtag_tdi_i),
    .tap_ctrl_o (tap_ctrl),
    .ir_tdo_o   (ir_tdo),
    .ir_shift_o (ir_shift)
  );

  dmi_scan dmi_scan_i (
    .jtag_tck    (jtag_tck),
    .rst_i       (rst_i),
    .jtag_tdi_i  (jtag_tdi_i),
    .tap_ctrl_i  (tap_ctrl),
    .ir_tdo_i    (ir_tdo),
    .ir_shift_i  (ir_shift),
    .dmi_rsp_i   (dmi_rsp),
    .dmi_req_o   (dmi_req),
    .req_valid_o (req_valid),
    .jtag_tdo_o  (jtag_tdo_o)
  );

  sb_access sb_access_i (
    .jtag_tck    (jtag_tck),
    .rst_i       (rst_i),
    .dmi_req_i   (dmi_req),
    .req_valid_i (req_valid),
    .dmi_rsp_o   (dmi_rsp),
    .mem_we_o    (mem_we),
    .mem_re_o    (mem_re),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  scratch_mem scratch_mem_i (
    .jtag_tck (jtag_tck),
    .we_i     (mem_we),
    .re_i     (mem_re),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rdata_o  (mem_rdata)
  );

endmodule

/* source/scratch_mem.sv */
/*
 * Scratch memory on the system bus
 * Single port, one word per address, registered read
 */

`timescale 1ns/10ps

`include "jtag_dbg_consts.svh"

module scratch_mem (
  input  logic               jtag_tck,
  input  logic               we_i,
  input  logic               re_i,
  input  logic [`MEM_AW-1:0] addr_i,
  input  logic [`DATA_W-1:0] wdata_i,
  output logic [`DATA_W-1:0] rdata_o
);

  logic [`DATA_W-1:0] mem_q [`MEM_WORDS];
  logic [`DATA_W-1:0] rdata_q;

  always_ff @(posedge jtag_tck) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    // Data shows up the cycle after re_i
    if (re_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* source/sb_access.sv */
/*
 * System bus access unit
 * SBCS, SBAddress0 and SBData0 registers, read-on-address,
 * read-on-data, auto-increment and the bad-address error
 */

`timescale 1ns/10ps

`include "jtag_dbg_consts.svh"

module sb_access (
  input  logic                 jtag_tck,
  input  logic                 rst_i,
  input  dmi_pkg::dmi_req_t    dmi_req_i,
  input  logic                 req_valid_i,
  output dmi_pkg::dmi_rsp_t    dmi_rsp_o,
  output logic                 mem_we_o,
  output logic                 mem_re_o,
  output logic [`MEM_AW-1:0]   mem_addr_o,
  output logic [`DATA_W-1:0]   mem_wdata_o,
  input  logic [`DATA_W-1:0]   mem_rdata_i
);

  dmi_pkg::sbcs_t     sbcs_q, sb_wdata;
  logic [`DATA_W-1:0] sbaddr_q, sbdata_q;
  dmi_pkg::dmi_rsp_t  rsp_q;
  logic               rd_pend_q;

  logic               is_wr, is_rd;
  logic               wr_sbcs, wr_addr, wr_data, rd_data;
  logic               err_clear, acc_req, acc_bad, acc_go;
  logic [`DATA_W-1:0] acc_addr, rd_val;

  ////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////

  assign is_wr   = req_valid_i && (dmi_req_i.op == dmi_pkg::WRITE);
  assign is_rd   = req_valid_i && (dmi_req_i.op == dmi_pkg::READ);
  assign wr_sbcs = is_wr && (dmi_req_i.addr == dmi_pkg::SBCS);
  assign wr_addr = is_wr && (dmi_req_i.addr == dmi_pkg::SBAddress0);
  assign wr_data = is_wr && (dmi_req_i.addr == dmi_pkg::SBData0);
  assign rd_data = is_rd && (dmi_req_i.addr == dmi_pkg::SBData0);

  assign sb_wdata  = dmi_pkg::sbcs_t'(dmi_req_i.data);
  assign err_clear = (sbcs_q.sberror == 3'd0);

  ////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////

  assign acc_req = (wr_addr && sbcs_q.sbreadonaddr) || wr_data ||
                   (rd_data && sbcs_q.sbreadondata);

  // A fresh address write is used right away
  assign acc_addr = wr_addr ? dmi_req_i.data : sbaddr_q;
  assign acc_bad  = (acc_addr[`DATA_W-1:`MEM_AW+2] != '0);
  assign acc_go   = acc_req && err_clear && !acc_bad;

  assign mem_we_o    = acc_go && wr_data;
  assign mem_re_o    = acc_go && !wr_data;
  assign mem_addr_o  = acc_addr[`MEM_AW+1:2];
  assign mem_wdata_o = dmi_req_i.data;

  // Readback mux, unknown addresses give zero
  always_comb begin
    case (dmi_req_i.addr)
      dmi_pkg::SBCS:       rd_val = sbcs_q;
      dmi_pkg::SBAddress0: rd_val = sbaddr_q;
      dmi_pkg::SBData0:    rd_val = sbdata_q;
      default:             rd_val = '0;
    endcase
  end

  always_ff @(posedge jtag_tck) begin
    if (rst_i) begin
      sbcs_q    <= dmi_pkg::sbcs_t'(`SBCS_RESET);
      rsp_q     <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_re_o;
      if (wr_sbcs) begin
        sbcs_q.sbreadonaddr    <= sb_wdata.sbreadonaddr;
        sbcs_q.sbautoincrement <= sb_wdata.sbautoincrement;
        sbcs_q.sbreadondata    <= sb_wdata.sbreadondata;
        // Write 1 to clear
        sbcs_q.sberror         <= sbcs_q.sberror & ~sb_wdata.sberror;
      end else if (acc_req && err_clear && acc_bad) begin
        sbcs_q.sberror <= `SB_ERR_BADADDR;
      end
      if (is_rd) begin
        rsp_q.data   <= rd_val;
        rsp_q.status <= `DMI_STATUS_OK;
      end
    end
  end

  // Later assignments take priority
  always_ff @(posedge jtag_tck) begin
    if (wr_addr) sbaddr_q <= dmi_req_i.data;
    if (acc_go && sbcs_q.sbautoincrement) sbaddr_q <= acc_addr + `DATA_W'(4);
    if (wr_data && err_clear) sbdata_q <= dmi_req_i.data;
    if (rd_pend_q) sbdata_q <= mem_rdata_i;
  end

  assign dmi_rsp_o = rsp_q;

endmodule

/* source/dmi_scan.sv */
/*
 * JTAG data registers
 * IDCODE, BYPASS and 41-bit DMI shift chains,
 * DMI request decode at Update-DR and the TDO register
 */

`timescale 1ns/10ps

`include "jtag_dbg_consts.svh"

module dmi_scan (
  input  logic                    jtag_tck,
  input  logic                    rst_i,
  input  logic                    jtag_tdi_i,
  input  jtag_tap_pkg::tap_ctrl_t tap_ctrl_i,
  input  logic                    ir_tdo_i,
  input  logic                    ir_shift_i,
  input  dmi_pkg::dmi_rsp_t       dmi_rsp_i,
  output dmi_pkg::dmi_req_t       dmi_req_o,
  output logic                    req_valid_o,
  output logic                    jtag_tdo_o
);

  localparam int DmiW = $bits(dmi_pkg::dmi_req_t);

  logic [`DATA_W-1:0] idcode_sr_q, idcode_sr_d;
  logic               bypass_sr_q, bypass_sr_d;
  logic [DmiW-1:0]    dmi_sr_q, dmi_sr_d;
  logic               sel_idcode, sel_dmi, dr_tdo;
  dmi_pkg::dmi_req_t  scan_req, dmi_req_q;
  logic               req_valid_q, tdo_q;

  assign sel_idcode = (tap_ctrl_i.ir == jtag_tap_pkg::IDCODE);
  assign sel_dmi    = (tap_ctrl_i.ir == jtag_tap_pkg::DMI_ACCESS);
  assign scan_req   = dmi_pkg::dmi_req_t'(dmi_sr_q);

  // Only the chain picked by the instruction moves
  always_comb begin
    idcode_sr_d = idcode_sr_q;
    bypass_sr_d = bypass_sr_q;
    dmi_sr_d    = dmi_sr_q;
    if (tap_ctrl_i.capture_dr) begin
      if (sel_idcode) idcode_sr_d = `JTAG_IDCODE;
      else if (sel_dmi) dmi_sr_d = {{`DMI_ABITS{1'b0}}, dmi_rsp_i.data, dmi_rsp_i.status};
      else bypass_sr_d = 1'b0;
    end else if (tap_ctrl_i.shift_dr) begin
      if (sel_idcode) idcode_sr_d = {jtag_tdi_i, idcode_sr_q[`DATA_W-1:1]};
      else if (sel_dmi) dmi_sr_d = {jtag_tdi_i, dmi_sr_q[DmiW-1:1]};
      else bypass_sr_d = jtag_tdi_i;
    end
  end

  // LSB of the active chain after this edge
  assign dr_tdo = sel_dmi ? dmi_sr_d[0] : (sel_idcode ? idcode_sr_d[0] : bypass_sr_d);

  always_ff @(posedge jtag_tck) begin
    if (rst_i) begin
      req_valid_q <= 1'b0;
      tdo_q       <= 1'b0;
    end else begin
      req_valid_q <= tap_ctrl_i.update_dr && sel_dmi && (scan_req.op != dmi_pkg::NOP);
      tdo_q       <= ir_shift_i ? ir_tdo_i : dr_tdo;
    end
  end

  always_ff @(posedge jtag_tck) begin
    idcode_sr_q <= idcode_sr_d;
    bypass_sr_q <= bypass_sr_d;
    // Stale requests do not survive a TAP reset
    if (tap_ctrl_i.test_logic_reset) dmi_sr_q <= '0;
    else dmi_sr_q <= dmi_sr_d;
    if (tap_ctrl_i.update_dr && sel_dmi) dmi_req_q <= scan_req;
  end

  assign dmi_req_o   = dmi_req_q;
  assign req_valid_o = req_valid_q;
  assign jtag_tdo_o  = tdo_q;

endmodule

/* source/jtag_tap_ctrl.sv */
/*
 * IEEE 1149.1 TAP controller
 * State machine, instruction shift and update registers,
 * and the decoded control bundle for the data registers
 */

`timescale 1ns/10ps

`include "jtag_dbg_consts.svh"

module jtag_tap_ctrl (
  input  logic                   jtag_tck,
  input  logic                   rst_i,
  input  logic                   jtag_tms_i,
  input  logic                   jtag_tdi_i,
  output jtag_tap_pkg::tap_ctrl_t tap_ctrl_o,
  output logic                   ir_tdo_o,
  output logic                   ir_shift_o
);

  jtag_tap_pkg::tap_state_e state_q, state_d;
  jtag_tap_pkg::ir_e        ir_q;
  logic [`IR_LEN-1:0]       ir_sr_q, ir_sr_d;

  ////////////////////////////////////////
  // TAP state machine
  ////////////////////////////////////////

  always_comb begin
    case (state_q)
      jtag_tap_pkg::TestLogicReset:
        state_d = jtag_tms_i ? jtag_tap_pkg::TestLogicReset : jtag_tap_pkg::RunTestIdle;
      jtag_tap_pkg::RunTestIdle:
        state_d = jtag_tms_i ? jtag_tap_pkg::SelectDrScan : jtag_tap_pkg::RunTestIdle;
      jtag_tap_pkg::SelectDrScan:
        state_d = jtag_tms_i ? jtag_tap_pkg::SelectIrScan : jtag_tap_pkg::CaptureDr;
      jtag_tap_pkg::CaptureDr, jtag_tap_pkg::ShiftDr:
        state_d = jtag_tms_i ? jtag_tap_pkg::Exit1Dr : jtag_tap_pkg::ShiftDr;
      jtag_tap_pkg::Exit1Dr:
        state_d = jtag_tms_i ? jtag_tap_pkg::UpdateDr : jtag_tap_pkg::PauseDr;
      jtag_tap_pkg::PauseDr:
        state_d = jtag_tms_i ? jtag_tap_pkg::Exit2Dr : jtag_tap_pkg::PauseDr;
      jtag_tap_pkg::Exit2Dr:
        state_d = jtag_tms_i ? jtag_tap_pkg::UpdateDr : jtag_tap_pkg::ShiftDr;
      jtag_tap_pkg::SelectIrScan:
        state_d = jtag_tms_i ? jtag_tap_pkg::TestLogicReset : jtag_tap_pkg::CaptureIr;
      jtag_tap_pkg::CaptureIr, jtag_tap_pkg::ShiftIr:
        state_d = jtag_tms_i ? jtag_tap_pkg::Exit1Ir : jtag_tap_pkg::ShiftIr;
      jtag_tap_pkg::Exit1Ir:
        state_d = jtag_tms_i ? jtag_tap_pkg::UpdateIr : jtag_tap_pkg::PauseIr;
      jtag_tap_pkg::PauseIr:
        state_d = jtag_tms_i ? jtag_tap_pkg::Exit2Ir : jtag_tap_pkg::PauseIr;
      jtag_tap_pkg::Exit2Ir:
        state_d = jtag_tms_i ? jtag_tap_pkg::UpdateIr : jtag_tap_pkg::ShiftIr;
      // Both update states leave the same way
      default:
        state_d = jtag_tms_i ? jtag_tap_pkg::SelectDrScan : jtag_tap_pkg::RunTestIdle;
    endcase
  end

  ////////////////////////////////////////
  // Instruction register
  ////////////////////////////////////////

  // Capture pattern ends in 01 as 1149.1 requires
  always_comb begin
    ir_sr_d = ir_sr_q;
    if (state_q == jtag_tap_pkg::CaptureIr) begin
      ir_sr_d = `IR_LEN'(1);
    end else if (state_q == jtag_tap_pkg::ShiftIr) begin
      ir_sr_d = {jtag_tdi_i, ir_sr_q[`IR_LEN-1:1]};
    end
  end

  always_ff @(posedge jtag_tck) begin
    if (rst_i) begin
      state_q <= jtag_tap_pkg::TestLogicReset;
      ir_q    <= jtag_tap_pkg::IDCODE;
    end else begin
      state_q <= state_d;
      if (state_q == jtag_tap_pkg::TestLogicReset) begin
        ir_q <= jtag_tap_pkg::IDCODE;
      end else if (state_q == jtag_tap_pkg::UpdateIr) begin
        ir_q <= jtag_tap_pkg::ir_e'(ir_sr_q);
      end
    end
  end

  always_ff @(posedge jtag_tck) begin
    ir_sr_q <= ir_sr_d;
  end

  // IR bit that sits at the chain end after this edge
  assign ir_tdo_o   = ir_sr_d[0];
  assign ir_shift_o = (state_q == jtag_tap_pkg::CaptureIr) ||
                      (state_q == jtag_tap_pkg::ShiftIr);

  assign tap_ctrl_o.capture_dr       = (state_q == jtag_tap_pkg::CaptureDr);
  assign tap_ctrl_o.shift_dr         = (state_q == jtag_tap_pkg::ShiftDr);
  assign tap_ctrl_o.update_dr        = (state_q == jtag_tap_pkg::UpdateDr);
  assign tap_ctrl_o.test_logic_reset = (state_q == jtag_tap_pkg::TestLogicReset);
  assign tap_ctrl_o.ir               = ir_q;

endmodule

/* source/dmi_pkg.sv */
/*
 * Debug module interface types
 * Register addresses and ops, request and response
 * bundles, and the SBCS field layout
 */

package dmi_pkg;

  `include "jtag_dbg_consts.svh"

  typedef enum logic [`DMI_ABITS-1:0] {
    SBCS       = 7'h38,
    SBAddress0 = 7'h39,
    SBData0    = 7'h3c
  } dmi_addr_e;

  typedef enum logic [1:0] {
    NOP   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } dmi_op_e;

  // Same bit order as the 41-bit scan register
  typedef struct packed {
    dmi_addr_e          addr;
    logic [`DATA_W-1:0] data;
    dmi_op_e            op;
  } dmi_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [1:0]         status;
  } dmi_rsp_t;

  typedef struct packed {
    logic [2:0]  sbversion;
    logic [7:0]  zero_hi;
    logic        sbreadonaddr;
    logic [2:0]  sbaccess;
    logic        sbautoincrement;
    logic        sbreadondata;
    logic [2:0]  sberror;
    logic [11:0] zero_lo;
  } sbcs_t;

endpackage

/* source/jtag_tap_pkg.sv */
/*
 * TAP controller types
 * 16-state TAP FSM encoding, instruction opcodes
 * and the control bundle handed to the scan chains
 */

package jtag_tap_pkg;

  `include "jtag_dbg_consts.svh"

  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle,
    SelectDrScan, CaptureDr, ShiftDr, Exit1Dr, PauseDr, Exit2Dr, UpdateDr,
    SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_e;

  // Unlisted opcodes behave as BYPASS
  typedef enum logic [`IR_LEN-1:0] {
    IDCODE     = 5'h01,
    DMI_ACCESS = 5'h11,
    BYPASS     = 5'h1f
  } ir_e;

  typedef struct packed {
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic test_logic_reset;
    ir_e  ir;
  } tap_ctrl_t;

endpackage

/* source/jtag_dbg_consts.svh */
/*
 * Constants for the JTAG debug target
 * ID code, instruction and DMI widths,
 * scratch memory geometry and DMI reset values
 */

`ifndef JTAG_DBG_CONSTS_SVH
`define JTAG_DBG_CONSTS_SVH

// TAP identification
`define JTAG_IDCODE 32'h1c0ffee1
`define IR_LEN 5

// DMI and bus widths
`define DMI_ABITS 7
`define DATA_W 32

// Scratch memory, one word per entry
`define MEM_WORDS 256
`define MEM_AW 8

// SBCS after reset: sbversion 1, sbaccess 2 (32 bit)
`define SBCS_RESET 32'h2004_0000
`define DMI_STATUS_OK 2'd0
`define SB_ERR_BADADDR 3'd2

`endif
